// ==== design/modred_consts.svh ====
`ifndef MODRED_CONSTS_SVH
`define MODRED_CONSTS_SVH

// Datapath widths
`define OPERAND_BITS 96
`define WORD_BITS    32
`define CHUNK_BITS   6
`define NUM_CHUNKS   16
`define RES_BITS     10
`define SUM_BITS     14

`define MODULUS      997
`define FOLD_CONST   27     // 1024 mod 997

// Wishbone register map
`define ADR_BITS     5

`define REG_OPERAND0 5'h00  // Operand bits 31:0
`define REG_OPERAND1 5'h04  // Operand bits 63:32
`define REG_OPERAND2 5'h08  // Operand bits 95:64
`define REG_CTRL     5'h0C  // Bit 0 starts
`define REG_STATUS   5'h10  // Bit 0 busy, bit 1 done
`define REG_RESULT   5'h14  // Residue in bits 9:0

`endif

// ==== design/modred_pkg.sv ====
`include "modred_consts.svh"

package modred_pkg;

	typedef logic [`OPERAND_BITS-1:0] operand_t;
	typedef logic [`CHUNK_BITS-1:0]   chunk_t;
	typedef logic [`RES_BITS-1:0]     residue_t;
	typedef logic [`SUM_BITS-1:0]     sum_t;
	typedef residue_t [`NUM_CHUNKS-1:0] residue_bus_t;  // One residue per chunk

	typedef logic [`ADR_BITS-1:0]  wb_adr_t;
	typedef logic [`WORD_BITS-1:0] wb_data_t;

	typedef enum logic [1:0]
	{
		OP_IDLE,
		OP_BUSY,
		OP_DONE
	} op_state_t;

	// Weight of chunk idx is 2^(6*idx) mod 997
	function automatic residue_t chunk_weight(input int idx);
		int w;
		w = 1;
		for (int k = 0; k < idx; k++)
		begin
			w = (w * (1 << `CHUNK_BITS)) % `MODULUS;
		end
		return residue_t'(w);
	endfunction

endpackage

// ==== design/modred_wb_regs.sv ====
`include "modred_consts.svh"

module modred_wb_regs import modred_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  wb_data_t wb_wdata,
	output wb_data_t wb_rdata,
	output logic     wb_ack,
	output operand_t operand,
	output logic     start,
	input  residue_t result,
	input  logic     result_valid
);

	op_state_t state;
	op_state_t state_next;

	wb_data_t  op_word0;
	wb_data_t  op_word1;
	wb_data_t  op_word2;
	residue_t  result_q;
	wb_data_t  rd_data;

	logic      access;
	logic      wr_en;
	logic      start_req;
	logic      start_ok;
	logic      busy;
	logic      done;

	assign access    = wb_cyc && wb_stb && !wb_ack;  // New cycle, ack not yet given
	assign wr_en     = access && wb_we;
	assign start_req = wr_en && (wb_adr == `REG_CTRL) && wb_wdata[0];
	assign start_ok  = start_req && (state != OP_BUSY);  // Ignored while busy

	assign busy = (state == OP_BUSY);
	assign done = (state == OP_DONE);

	assign operand = {op_word2, op_word1, op_word0};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;  // Single cycle
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			op_word0 <= '0;
			op_word1 <= '0;
			op_word2 <= '0;
		end
		else if (wr_en)
		begin
			case (wb_adr)
				`REG_OPERAND0: op_word0 <= wb_wdata;
				`REG_OPERAND1: op_word1 <= wb_wdata;
				`REG_OPERAND2: op_word2 <= wb_wdata;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		rd_data = '0;
		case (wb_adr)
			`REG_OPERAND0: rd_data = op_word0;
			`REG_OPERAND1: rd_data = op_word1;
			`REG_OPERAND2: rd_data = op_word2;
			`REG_STATUS:   rd_data = wb_data_t'({done, busy});
			`REG_RESULT:   rd_data = wb_data_t'(result_q);
			default:       rd_data = '0;  // CTRL and holes read zero
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wb_rdata <= '0;
		else if (access && !wb_we)
			wb_rdata <= rd_data;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			OP_BUSY:
			begin
				if (result_valid)
					state_next = OP_DONE;
			end
			default:
			begin
				if (start_req)
					state_next = OP_BUSY;  // Also clears done
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= OP_IDLE;
			start    <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			state <= state_next;
			start <= start_ok;
			if (busy && result_valid)
				result_q <= result;
		end
	end

endmodule

// ==== design/modred_chunk_residue.sv ====
`include "modred_consts.svh"

module modred_chunk_residue import modred_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  operand_t     operand,
	input  logic         start,
	output residue_bus_t residues,
	output logic         res_valid
);

	localparam int PROD_BITS = `CHUNK_BITS + `RES_BITS;

	residue_bus_t res_next;

	genvar i;
	generate
		for (i = 0; i < `NUM_CHUNKS; i++)
		begin : g_chunk
			localparam residue_t WEIGHT = chunk_weight(i);

			chunk_t                 chunk;
			logic [PROD_BITS-1:0]   prod;
			logic [`RES_BITS+1:0]   fold1;
			logic [`RES_BITS:0]     fold2;

			assign chunk = operand[i*`CHUNK_BITS +: `CHUNK_BITS];
			assign prod  = PROD_BITS'(chunk) * PROD_BITS'(WEIGHT);  // At most 62748

			// Bits above 9 are worth 1024, which is 27 mod 997
			assign fold1 = (`RES_BITS+2)'(prod[`RES_BITS-1:0])
				+ (`RES_BITS+2)'(`FOLD_CONST) * (`RES_BITS+2)'(prod[PROD_BITS-1:`RES_BITS]);
			assign fold2 = (`RES_BITS+1)'(fold1[`RES_BITS-1:0])
				+ (`RES_BITS+1)'(`FOLD_CONST) * (`RES_BITS+1)'(fold1[`RES_BITS+1:`RES_BITS]);

			// Below 1105 here, one subtraction is enough
			assign res_next[i] = (fold2 >= (`RES_BITS+1)'(`MODULUS))
				? residue_t'(fold2 - (`RES_BITS+1)'(`MODULUS))
				: residue_t'(fold2);
		end
	endgenerate

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= start;
	end

	// Operand is sampled here, later register writes do not matter
	always_ff @(posedge clk)
	begin
		if (start)
			residues <= res_next;
	end

endmodule

// ==== design/modred_sum_fold.sv ====
`include "modred_consts.svh"

module modred_sum_fold import modred_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  residue_bus_t residues,
	input  logic         res_valid,
	output residue_t     result,
	output logic         result_valid
);

	localparam int FOLD_BITS = `RES_BITS + 1;

	sum_t                 sum_next;
	sum_t                 sum_q;
	logic                 sum_valid;
	logic [FOLD_BITS-1:0] fold_a;
	logic [FOLD_BITS-1:0] fold_b;
	residue_t             res_final;

	always_comb
	begin
		sum_next = '0;
		for (int k = 0; k < `NUM_CHUNKS; k++)
		begin
			sum_next = sum_next + sum_t'(residues[k]);  // Max 15936
		end
	end

	// Stage two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sum_valid <= 1'b0;
		else
			sum_valid <= res_valid;
	end

	always_ff @(posedge clk)
	begin
		if (res_valid)
			sum_q <= sum_next;
	end

	// Upper four bits folded back, below 1429
	assign fold_a = FOLD_BITS'(sum_q[`RES_BITS-1:0])
		+ FOLD_BITS'(`FOLD_CONST) * FOLD_BITS'(sum_q[`SUM_BITS-1:`RES_BITS]);

	// Bit 10 folded back, below 1051
	assign fold_b = FOLD_BITS'(fold_a[`RES_BITS-1:0])
		+ (fold_a[`RES_BITS] ? FOLD_BITS'(`FOLD_CONST) : '0);

	assign res_final = (fold_b >= FOLD_BITS'(`MODULUS))
		? residue_t'(fold_b - FOLD_BITS'(`MODULUS))
		: residue_t'(fold_b);

	// Stage three
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result_valid <= 1'b0;
			result       <= '0;
		end
		else
		begin
			result_valid <= sum_valid;
			if (sum_valid)
				result <= res_final;
		end
	end

endmodule

// ==== design/modred_top.sv ====
`include "modred_consts.svh"

module modred_top import modred_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  wb_data_t wb_wdata,
	output wb_data_t wb_rdata,
	output logic     wb_ack
);

	operand_t     operand;
	logic         start;
	residue_bus_t residues;
	logic         res_valid;
	residue_t     result;
	logic         result_valid;

	modred_wb_regs u_regs
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_wdata     (wb_wdata),
		.wb_rdata     (wb_rdata),
		.wb_ack       (wb_ack),
		.operand      (operand),
		.start        (start),
		.result       (result),
		.result_valid (result_valid)
	);

	modred_chunk_residue u_chunk
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.operand   (operand),
		.start     (start),
		.residues  (residues),
		.res_valid (res_valid)
	);

	// Sum and final reduction, two cycles
	modred_sum_fold u_fold
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.residues     (residues),
		.res_valid    (res_valid),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== verif/modred_assert.sv ====
`include "modred_consts.svh"

module modred_assert import modred_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     wb_cyc,
	input logic     wb_stb,
	input logic     wb_ack,
	input logic     start,
	input logic     result_valid,
	input residue_t result
);

	int failures;  // Read by the testbench

	initial
	begin
		failures = 0;
	end

	ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
	else
	begin
		failures++;
		$error("wb_ack held high for two cycles");
	end

	ack_after_request: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
	else
	begin
		failures++;
		$error("wb_ack without a preceding request");
	end

	// Three register stages from start to result
	start_to_result: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##3 result_valid)
	else
	begin
		failures++;
		$error("result_valid missing three cycles after start");
	end

	result_from_start: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> $past(start, 3))
	else
	begin
		failures++;
		$error("result_valid without start three cycles earlier");
	end

	result_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		result < `MODULUS)
	else
	begin
		failures++;
		$error("result %0d not below the modulus", result);
	end

endmodule

bind modred_top modred_assert u_assert
(
	.clk          (clk),
	.rst_n        (rst_n),
	.wb_cyc       (wb_cyc),
	.wb_stb       (wb_stb),
	.wb_ack       (wb_ack),
	.start        (start),
	.result_valid (result_valid),
	.result       (result)
);

// ==== verif/modred_tb.sv ====
`include "modred_consts.svh"

module modred_tb import modred_pkg::*;
();

	localparam int NUM_FIXED       = 10;
	localparam int NUM_RANDOM      = 8;
	localparam int NUM_VECTORS     = NUM_FIXED + NUM_RANDOM;
	localparam int CLK_PERIOD      = 10;
	localparam int WATCHDOG_CYCLES = NUM_VECTORS * 200 + 1000;  // Margin for directed tests

	logic     clk;
	logic     rst_n;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_adr_t  wb_adr;
	wb_data_t wb_wdata;
	wb_data_t wb_rdata;
	logic     wb_ack;

	operand_t    vec_op [NUM_VECTORS];
	residue_t    vec_exp [NUM_VECTORS];
	logic [15:0] lfsr_state;
	int          error_count;
	int          errors_at_start;
	int          test_count;
	int          failed_tests;

	modred_top u_modred_top
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic residue_t expected_residue(input operand_t op);
		return residue_t'(op % operand_t'(`MODULUS));
	endfunction

	task automatic random_operand(output operand_t op);
		op = '0;
		for (int b = 0; b < `OPERAND_BITS; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			op = {op[`OPERAND_BITS-2:0], lfsr_state[0]};  // One step per bit
		end
	endtask

	task automatic build_table();
		vec_op[0] = 96'd0;
		vec_op[1] = 96'd996;
		vec_op[2] = 96'd997;
		vec_op[3] = 96'd998;
		vec_op[4] = '1;
		vec_op[5] = operand_t'(1) << 95;
		vec_op[6] = 96'h0123_4567_89ab_cdef_fedc_ba98;
		vec_op[7] = 96'hffff_ffff_0000_0000_ffff_ffff;
		vec_op[8] = operand_t'(`MODULUS) * 96'd123456789;  // Exact multiple
		vec_op[9] = 96'h8000_0000_7fff_ffff_8000_03e4;
		for (int i = NUM_FIXED; i < NUM_VECTORS; i++)
		begin
			random_operand(vec_op[i]);
		end
		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			vec_exp[i] = expected_residue(vec_op[i]);
		end
	endtask

	// Master holds the request until ack, sampled on the falling edge
	task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_wdata = data;
		do
			@(negedge clk);
		while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		do
			@(negedge clk);
		while (!wb_ack);
		data   = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic write_operand(input operand_t op);
		wb_write(`REG_OPERAND0, op[31:0]);
		wb_write(`REG_OPERAND1, op[63:32]);
		wb_write(`REG_OPERAND2, op[95:64]);
	endtask

	task automatic start_operation();
		wb_write(`REG_CTRL, 32'h1);
	endtask

	task automatic wait_done();
		wb_data_t st;
		st = '0;
		while (!st[1])
			wb_read(`REG_STATUS, st);
	endtask

	task automatic report_mismatch(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count == errors_at_start)
			$display("Test %s: passed", name);
		else
		begin
			failed_tests++;
			$display("Test %s: failed", name);
		end
		errors_at_start = error_count;
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		wb_data_t rd;
		wb_data_t words [3];
		operand_t op_a;
		operand_t op_b;
		rst_n           = 1'b0;
		wb_cyc          = 1'b0;
		wb_stb          = 1'b0;
		wb_we           = 1'b0;
		wb_adr          = '0;
		wb_wdata        = '0;
		lfsr_state      = 16'd11;
		error_count     = 0;
		errors_at_start = 0;
		test_count      = 0;
		failed_tests    = 0;
		build_table();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		for (int a = `REG_OPERAND0; a <= `REG_RESULT; a += 4)
		begin
			wb_read(wb_adr_t'(a), rd);
			if (rd !== '0)
				report_mismatch($sformatf("reg 0x%02h reads 0x%08h after reset", a, rd));
		end
		finish_test("reset values");

		words[0] = 32'hdead_beef;
		words[1] = 32'h1234_5678;
		words[2] = 32'ha5a5_5a5a;
		for (int w = 0; w < 3; w++)
			wb_write(wb_adr_t'(4 * w), words[w]);
		for (int w = 0; w < 3; w++)
		begin
			wb_read(wb_adr_t'(4 * w), rd);
			if (rd !== words[w])
				report_mismatch($sformatf("operand word %0d reads 0x%08h, wrote 0x%08h",
					w, rd, words[w]));
		end
		finish_test("operand readback");

		for (int i = 0; i < NUM_VECTORS; i++)
		begin
			write_operand(vec_op[i]);
			start_operation();
			wait_done();
			wb_read(`REG_RESULT, rd);
			if (rd !== wb_data_t'(vec_exp[i]))
				report_mismatch($sformatf("vector %0d result %0d, expected %0d",
					i, rd, vec_exp[i]));
			finish_test($sformatf("vector %0d", i));
		end

		op_a = vec_op[6];
		write_operand(op_a);
		start_operation();
		wb_read(`REG_STATUS, rd);
		if (rd !== 32'h1)
			report_mismatch($sformatf("status 0x%0h while running, expected busy only", rd));
		wait_done();
		wb_read(`REG_STATUS, rd);
		if (rd !== 32'h2)
			report_mismatch($sformatf("status 0x%0h after completion, expected done", rd));
		start_operation();  // Done must clear again
		wb_read(`REG_STATUS, rd);
		if (rd !== 32'h1)
			report_mismatch($sformatf("status 0x%0h after restart, expected busy only", rd));
		wait_done();
		wb_read(`REG_RESULT, rd);
		if (rd !== wb_data_t'(expected_residue(op_a)))
			report_mismatch($sformatf("restart result %0d, expected %0d",
				rd, expected_residue(op_a)));
		finish_test("status flags");

		op_a = vec_op[7];
		op_b = vec_op[6];
		write_operand(op_a);
		start_operation();
		wb_write(`REG_OPERAND0, op_b[31:0]);
		start_operation();  // Still busy, must be dropped
		wb_write(`REG_OPERAND1, op_b[63:32]);
		wb_write(`REG_OPERAND2, op_b[95:64]);
		wait_done();
		wb_read(`REG_STATUS, rd);
		if (rd !== 32'h2)
			report_mismatch($sformatf("status 0x%0h after ignored start, expected done", rd));
		wb_read(`REG_RESULT, rd);
		if (rd !== wb_data_t'(expected_residue(op_a)))
			report_mismatch($sformatf("result %0d after ignored start, expected %0d",
				rd, expected_residue(op_a)));
		finish_test("start while busy");

		error_count += u_modred_top.u_assert.failures;
		$display("Tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
			test_count, failed_tests, error_count, u_modred_top.u_assert.failures);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+design
design/modred_pkg.sv
design/modred_wb_regs.sv
design/modred_chunk_residue.sv
design/modred_sum_fold.sv
design/modred_top.sv
verif/modred_assert.sv
verif/modred_tb.sv

// ==== Bender.yml ====
package:
  name: modred

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/modred_pkg.sv
      - design/modred_wb_regs.sv
      - design/modred_chunk_residue.sv
      - design/modred_sum_fold.sv
      - design/modred_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/modred_assert.sv
      - verif/modred_tb.sv
